//--- compile.f
source/key_extract_pkg.sv
source/ctrl_decode.sv
source/key_table.sv
source/key_execute.sv
source/key_result.sv
source/key_extract_top.sv
tests/tb_clock.sv
tests/key_extract_assertions.sv
tests/key_extract_tb.sv

//--- run.sh
#!/bin/sh
# build and run the key extraction testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module key_extract_tb -Mdir obj_dir -o key_extract_sim

# the verdict comes from the simulation output
out=$(./obj_dir/key_extract_sim 2>&1) || true
echo "$out"
if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1

//--- tests/key_extract_tb.sv
`timescale 1ns/1ns
// testbench for the key extraction stage
// random table writes, foreign control packets and phv traffic,
// reference model of tables, containers and comparator, closing verdict
module key_extract_tb;

    localparam int stage_id    = 2;
    localparam int key_ex_id   = 3;
    localparam int num_phv     = 300;
    localparam int num_foreign = 8;
    localparam int gap_cycles  = 120;
    localparam int depth       = key_extract_pkg::table_depth;
    // table packets may double with gaps, foreign packets are at most 4 beats
    localparam int max_cycles  = 4 + 4 * (depth + 1) + 5 * num_foreign + depth
                               + 2 * num_phv + gap_cycles + 200;
    localparam logic [7:0] match_id = 8'(stage_id * 8 + key_ex_id);
    localparam int op_msb      = key_extract_pkg::op_base + 99 - 20 * stage_id;
    localparam int tenant_lsb  = key_extract_pkg::vlan_lsb + 4;

    logic                   clk;
    logic                   rst_n;
    key_extract_pkg::phv_t  phv_in;
    logic                   phv_valid;
    key_extract_pkg::ctrl_t ctrl_data;
    logic                   ctrl_valid;
    logic                   ctrl_last;
    key_extract_pkg::phv_t  phv_out;
    logic                   phv_valid_out;
    key_extract_pkg::key_t  key_out;
    logic                   key_valid_out;
    key_extract_pkg::key_t  key_mask_out;
    key_extract_pkg::ctrl_t ctrl_data_out;
    logic                   ctrl_valid_out;
    logic                   ctrl_last_out;

    // model tables and saved traffic
    logic [17:0]            off_model [depth];
    key_extract_pkg::mask_t mask_model [depth];
    key_extract_pkg::phv_t  saved_phv [num_phv];

    // expected phv path results, three cycles deep
    logic                   exp_valid_q [$];
    key_extract_pkg::phv_t  exp_phv_q [$];
    key_extract_pkg::key_t  exp_key_q [$];
    key_extract_pkg::key_t  exp_mask_q [$];
    logic                   fwd_flag;
    logic                   exp_cvalid;
    key_extract_pkg::ctrl_t exp_cdata;
    logic                   exp_clast;

    int seed;
    int errors;
    int checks;
    int cycles;
    int assert_fails;
    int i;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    key_extract_top #(
        .STAGE_ID  (stage_id),
        .KEY_EX_ID (key_ex_id)
    ) i_key_extract_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid      (phv_valid),
        .ctrl_data      (ctrl_data),
        .ctrl_valid     (ctrl_valid),
        .ctrl_last      (ctrl_last),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out        (key_out),
        .key_valid_out  (key_valid_out),
        .key_mask_out   (key_mask_out),
        .ctrl_data_out  (ctrl_data_out),
        .ctrl_valid_out (ctrl_valid_out),
        .ctrl_last_out  (ctrl_last_out)
    );

    // size code 2 is 6B, 1 is 4B, anything else 2B
    function automatic logic [47:0] container(input key_extract_pkg::phv_t p,
                                              input logic [1:0] size, input logic [2:0] idx);
        logic [47:0] c;
        case (size)
            2'd2:    c = p[key_extract_pkg::cont_6b_lsb + 48 * int'(idx) +: 48];
            2'd1:    c = {16'd0, p[key_extract_pkg::cont_4b_lsb + 32 * int'(idx) +: 32]};
            default: c = {32'd0, p[key_extract_pkg::cont_2b_lsb + 16 * int'(idx) +: 16]};
        endcase
        return c;
    endfunction

    function automatic logic [7:0] operand(input key_extract_pkg::phv_t p,
                                           input logic [8:0] desc);
        if (desc[8]) begin
            return desc[7:0];
        end
        return 8'(container(p, desc[4:3], desc[2:0]));
    endfunction

    function automatic key_extract_pkg::key_t model_key(input key_extract_pkg::phv_t p,
                                                       input logic [17:0] off);
        key_extract_pkg::key_t k;
        logic [19:0]           op;
        logic [7:0]            a;
        logic [7:0]            b;
        op = p[op_msb -: 20];
        a = operand(p, op[17:9]);
        b = operand(p, op[8:0]);
        k = '0;
        k[196:149] = container(p, 2'd2, off[17:15]);
        k[148:101] = container(p, 2'd2, off[14:12]);
        k[100:69] = 32'(container(p, 2'd1, off[11:9]));
        k[68:37] = 32'(container(p, 2'd1, off[8:6]));
        k[36:21] = 16'(container(p, 2'd0, off[5:3]));
        k[20:5] = 16'(container(p, 2'd0, off[2:0]));
        case (op[19:18])
            2'd0:    k[4-stage_id] = a > b;
            2'd1:    k[4-stage_id] = a >= b;
            2'd2:    k[4-stage_id] = a == b;
            default: k[4-stage_id] = 1'b1;
        endcase
        return k;
    endfunction

    function automatic key_extract_pkg::ctrl_t rand_ctrl();
        key_extract_pkg::ctrl_t c;
        int w;
        for (w = 0; w < 8; w++) begin
            c[w*32 +: 32] = $random(seed);
        end
        return c;
    endfunction

    // random phv with a crafted opcode in this stage's slot
    function automatic key_extract_pkg::phv_t make_phv(input logic [3:0] tenant,
                                                      input logic force_tenant);
        logic [36*32-1:0]      wide;
        key_extract_pkg::phv_t p;
        logic [31:0]           r;
        logic [8:0]            da;
        logic [8:0]            db;
        int w;
        for (w = 0; w < 36; w++) begin
            wide[w*32 +: 32] = $random(seed);
        end
        p = wide[key_extract_pkg::phv_len-1:0];
        r = $random(seed);
        da = r[8:0];
        db = r[17:9];
        // same operand twice so the equal kind also comes out true
        if (r[20:18] == 3'd0) begin
            db = da;
        end
        p[op_msb -: 20] = {r[22:21], da, db};
        if (force_tenant) begin
            p[tenant_lsb +: 4] = tenant;
        end
        return p;
    endfunction

    task automatic drive_cycle(input key_extract_pkg::phv_t p, input logic pv,
                               input key_extract_pkg::ctrl_t c, input logic cv,
                               input logic cl, input logic fwd);
        @(posedge clk);
        phv_in     <= p;
        phv_valid  <= pv;
        ctrl_data  <= c;
        ctrl_valid <= cv;
        ctrl_last  <= cl;
        fwd_flag    = cv && fwd;
    endtask

    task automatic send_table_packet(input logic to_mask);
        key_extract_pkg::ctrl_t beat;
        logic [31:0]            r;
        logic [3:0]             idx;
        int k;
        r = $random(seed);
        beat = rand_ctrl();
        beat[255:248] = match_id;
        beat[247:244] = to_mask ? ((r[7:4] == 4'd0) ? 4'd9 : r[7:4]) : 4'd0;
        beat[243:240] = r[3:0];
        idx = r[3:0];
        drive_cycle('0, 1'b0, beat, 1'b1, 1'b0, 1'b0);
        for (k = 0; k < depth; k++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                drive_cycle('0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
            end
            beat = rand_ctrl();
            if (to_mask) begin
                mask_model[idx] = beat[key_extract_pkg::key_len-1:0];
            end else begin
                off_model[idx] = beat[17:0];
            end
            drive_cycle('0, 1'b0, beat, 1'b1, k == depth - 1, 1'b0);
            idx = idx + 4'd1;
        end
    endtask

    // even packets miss on extractor id, odd ones on stage
    task automatic send_foreign_packet(input int n);
        key_extract_pkg::ctrl_t beat;
        logic [31:0]            r;
        int len;
        int k;
        r = $random(seed);
        len = 1 + int'(r[1:0]);
        beat = rand_ctrl();
        if (n % 2 == 0) begin
            beat[255:248] = {match_id[7:3],
                             match_id[2:0] ^ ((r[4:2] == 3'd0) ? 3'd1 : r[4:2])};
        end else begin
            beat[255:248] = {match_id[7:3] ^ ((r[9:5] == 5'd0) ? 5'd1 : r[9:5]),
                             match_id[2:0]};
        end
        for (k = 0; k < len; k++) begin
            if (k > 0) begin
                beat = rand_ctrl();
                // data beat that looks like a matching header
                if (r[10]) begin
                    beat[255:248] = match_id;
                end
            end
            drive_cycle('0, 1'b0, beat, 1'b1, k == len - 1, 1'b1);
        end
    endtask

    task automatic check_phv(input string what, input key_extract_pkg::phv_t got,
                             input key_extract_pkg::phv_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s differs from the phv sent", $time, what);
        end
    endtask

    task automatic check_key(input string what, input key_extract_pkg::key_t got,
                             input key_extract_pkg::key_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ctrl(input string what, input key_extract_pkg::ctrl_t got,
                              input key_extract_pkg::ctrl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // outputs are compared on the falling edge
    always @(negedge clk) begin : monitor
        logic                  ev;
        key_extract_pkg::phv_t ep;
        key_extract_pkg::key_t ek;
        key_extract_pkg::key_t em;
        logic [3:0]            ten;
        if (rst_n) begin
            ten = phv_in[tenant_lsb +: 4];
            exp_valid_q.push_back(phv_valid);
            exp_phv_q.push_back(phv_in);
            exp_key_q.push_back(model_key(phv_in, off_model[ten]));
            exp_mask_q.push_back(mask_model[ten]);
            if (exp_valid_q.size() > 3) begin
                ev = exp_valid_q.pop_front();
                ep = exp_phv_q.pop_front();
                ek = exp_key_q.pop_front();
                em = exp_mask_q.pop_front();
                check_bit("phv_valid_out", phv_valid_out, ev);
                check_bit("key_valid_out", key_valid_out, ev);
                if (ev) begin
                    check_phv("phv_out", phv_out, ep);
                    check_key("key_out", key_out, ek);
                    check_key("key_mask_out", key_mask_out, em);
                end else begin
                    check_key("key_out in idle cycle", key_out, '0);
                end
            end
            check_bit("ctrl_valid_out", ctrl_valid_out, exp_cvalid);
            if (exp_cvalid) begin
                check_ctrl("ctrl_data_out", ctrl_data_out, exp_cdata);
                check_bit("ctrl_last_out", ctrl_last_out, exp_clast);
            end else begin
                check_bit("ctrl_last_out", ctrl_last_out, 1'b0);
            end
            exp_cvalid = fwd_flag;
            exp_cdata  = ctrl_data;
            exp_clast  = ctrl_last;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        seed       = 17444;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        phv_in     = '0;
        phv_valid  = 1'b0;
        ctrl_data  = '0;
        ctrl_valid = 1'b0;
        ctrl_last  = 1'b0;
        fwd_flag   = 1'b0;
        exp_cvalid = 1'b0;
        exp_cdata  = '0;
        exp_clast  = 1'b0;
        @(posedge rst_n);
        repeat (2) drive_cycle('0, 1'b0, '0, 1'b0, 1'b0, 1'b0);

        // fill both tables, then one phv per tenant
        send_table_packet(1'b0);
        send_table_packet(1'b1);
        repeat (4) drive_cycle('0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        for (i = 0; i < depth; i++) begin
            drive_cycle(make_phv(4'(i), 1'b1), 1'b1, '0, 1'b0, 1'b0, 1'b0);
        end

        // back-to-back traffic with random opcodes
        for (i = 0; i < num_phv; i++) begin
            saved_phv[i] = make_phv(4'd0, 1'b0);
            drive_cycle(saved_phv[i], 1'b1, '0, 1'b0, 1'b0, 1'b0);
        end
        repeat (4) drive_cycle('0, 1'b0, '0, 1'b0, 1'b0, 1'b0);

        // foreign packets must leave the tables alone
        for (i = 0; i < num_foreign; i++) begin
            send_foreign_packet(i);
        end
        repeat (2) drive_cycle('0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        for (i = 0; i < num_phv; i++) begin
            drive_cycle(saved_phv[i], 1'b1, '0, 1'b0, 1'b0, 1'b0);
        end

        // random idle gaps
        for (i = 0; i < gap_cycles; i++) begin
            drive_cycle(make_phv(4'd0, 1'b0), 1'($random(seed)), '0, 1'b0, 1'b0, 1'b0);
        end
        repeat (6) drive_cycle('0, 1'b0, '0, 1'b0, 1'b0, 1'b0);

        assert_fails = i_key_extract_top.protocol_checks.fail_count;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tests/key_extract_assertions.sv
`timescale 1ns/1ns
// concurrent checks bound to the key extraction top level
// phv and key valid timing, control output quiet during table writes
module key_extract_assertions (
    input logic clk,
    input logic rst_n,
    input logic phv_valid,
    input logic phv_valid_out,
    input logic key_valid_out,
    input logic ctrl_valid_out,
    input logic off_wr_en,
    input logic mask_wr_en
);

    int fail_count = 0;

    // fixed three cycle pipeline without back-pressure
    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out == $past(phv_valid, 3))
    else begin
        $error("phv_valid_out does not follow phv_valid three cycles later");
        fail_count++;
    end

    // key valid leaves together with phv valid
    key_valid_match: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid_out == $past(phv_valid, 3))
    else begin
        $error("key_valid_out does not follow phv_valid three cycles later");
        fail_count++;
    end

    // neither a written beat nor the beat before it is forwarded
    quiet_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        (off_wr_en || mask_wr_en) |=> !ctrl_valid_out && !$past(ctrl_valid_out))
    else begin
        $error("ctrl_valid_out high around a table write beat");
        fail_count++;
    end

endmodule

bind key_extract_top key_extract_assertions protocol_checks (
    .clk            (clk),
    .rst_n          (rst_n),
    .phv_valid      (phv_valid),
    .phv_valid_out  (phv_valid_out),
    .key_valid_out  (key_valid_out),
    .ctrl_valid_out (ctrl_valid_out),
    .off_wr_en      (off_wr_en),
    .mask_wr_en     (mask_wr_en)
);

//--- tests/tb_clock.sv
`timescale 1ns/1ns
// clock and reset generator for the key extraction testbench
module tb_clock #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- source/key_extract_top.sv
`timescale 1ns/1ns
// key extraction stage top level
// control decoder, offset and mask tenant tables,
// execute and result stages of the phv path
module key_extract_top #(
    parameter int STAGE_ID  = 0,
    parameter int KEY_EX_ID = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  key_extract_pkg::phv_t  phv_in,
    input  logic                   phv_valid,
    input  key_extract_pkg::ctrl_t ctrl_data,
    input  logic                   ctrl_valid,
    input  logic                   ctrl_last,
    output key_extract_pkg::phv_t  phv_out,
    output logic                   phv_valid_out,
    output key_extract_pkg::key_t  key_out,
    output logic                   key_valid_out,
    output key_extract_pkg::key_t  key_mask_out,
    output key_extract_pkg::ctrl_t ctrl_data_out,
    output logic                   ctrl_valid_out,
    output logic                   ctrl_last_out
);

    logic [key_extract_pkg::vlan_msb-key_extract_pkg::vlan_lsb:0] vlan_id;
    logic [key_extract_pkg::tenant_w-1:0] tenant;

    logic [key_extract_pkg::tenant_w-1:0] wr_index;
    logic                                 off_wr_en;
    logic                                 mask_wr_en;
    key_extract_pkg::ctrl_t               wr_data;
    key_extract_pkg::offset_t             off_wr_data;
    key_extract_pkg::mask_t               mask_wr_data;

    key_extract_pkg::offset_t             offsets;
    key_extract_pkg::mask_t               mask;

    key_extract_pkg::phv_t                phv_d;
    logic                                 valid_d;
    key_extract_pkg::cont_6b_t            cont_6b;
    key_extract_pkg::cont_4b_t            cont_4b;
    key_extract_pkg::cont_2b_t            cont_2b;
    logic                                 cmp_bit;

    // tenant comes from vlan id bits 7:4
    assign vlan_id = phv_in[key_extract_pkg::vlan_msb:key_extract_pkg::vlan_lsb];
    assign tenant  = vlan_id[7:4];

    // table entries sit in the low bits of a data beat
    assign off_wr_data  = wr_data[$bits(key_extract_pkg::offset_t)-1:0];
    assign mask_wr_data = wr_data[$bits(key_extract_pkg::mask_t)-1:0];

    ctrl_decode #(
        .STAGE_ID  (STAGE_ID),
        .KEY_EX_ID (KEY_EX_ID)
    ) decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_data      (ctrl_data),
        .ctrl_valid     (ctrl_valid),
        .ctrl_last      (ctrl_last),
        .wr_index       (wr_index),
        .off_wr_en      (off_wr_en),
        .mask_wr_en     (mask_wr_en),
        .wr_data        (wr_data),
        .ctrl_data_out  (ctrl_data_out),
        .ctrl_valid_out (ctrl_valid_out),
        .ctrl_last_out  (ctrl_last_out)
    );

    key_table #(
        .entry_t (key_extract_pkg::offset_t)
    ) offset_table (
        .clk      (clk),
        .wr_en    (off_wr_en),
        .wr_index (wr_index),
        .wr_data  (off_wr_data),
        .rd_index (tenant),
        .rd_data  (offsets)
    );

    key_table #(
        .entry_t (key_extract_pkg::mask_t)
    ) mask_table (
        .clk      (clk),
        .wr_en    (mask_wr_en),
        .wr_index (wr_index),
        .wr_data  (mask_wr_data),
        .rd_index (tenant),
        .rd_data  (mask)
    );

    key_execute #(
        .STAGE_ID (STAGE_ID)
    ) execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .phv_in    (phv_in),
        .phv_valid (phv_valid),
        .phv_d     (phv_d),
        .valid_d   (valid_d),
        .cont_6b   (cont_6b),
        .cont_4b   (cont_4b),
        .cont_2b   (cont_2b),
        .cmp_bit   (cmp_bit)
    );

    key_result #(
        .STAGE_ID (STAGE_ID)
    ) result (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_d         (phv_d),
        .valid_d       (valid_d),
        .cont_6b       (cont_6b),
        .cont_4b       (cont_4b),
        .cont_2b       (cont_2b),
        .cmp_bit       (cmp_bit),
        .offsets       (offsets),
        .mask          (mask),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

//--- source/key_result.sv
`timescale 1ns/1ns
// result stage of the key extractor
// key assembly from the tenant offsets, comparator bit placement,
// output registers for phv, key and key mask
module key_result #(
    parameter int STAGE_ID = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  key_extract_pkg::phv_t     phv_d,
    input  logic                      valid_d,
    input  key_extract_pkg::cont_6b_t cont_6b,
    input  key_extract_pkg::cont_4b_t cont_4b,
    input  key_extract_pkg::cont_2b_t cont_2b,
    input  logic                      cmp_bit,
    input  key_extract_pkg::offset_t  offsets,
    input  key_extract_pkg::mask_t    mask,
    output key_extract_pkg::phv_t     phv_out,
    output logic                      phv_valid_out,
    output key_extract_pkg::key_t     key_out,
    output logic                      key_valid_out,
    output key_extract_pkg::key_t     key_mask_out
);

    // one bit per comparator slot, slot 0 at the top
    logic [key_extract_pkg::num_slots-1:0] cmp_field;
    key_extract_pkg::key_t                 key_next;

    always_comb begin
        cmp_field = '0;
        cmp_field[key_extract_pkg::num_slots-1-STAGE_ID] = cmp_bit;
    end

    // 6B pair, 4B pair, 2B pair, then the comparator bits
    assign key_next = {
        cont_6b[offsets.sel_6b_hi],
        cont_6b[offsets.sel_6b_lo],
        cont_4b[offsets.sel_4b_hi],
        cont_4b[offsets.sel_4b_lo],
        cont_2b[offsets.sel_2b_hi],
        cont_2b[offsets.sel_2b_lo],
        cmp_field
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_valid_out <= 1'b0;
            key_valid_out <= 1'b0;
        end else begin
            phv_valid_out <= valid_d;
            key_valid_out <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        phv_out <= phv_d;
        // zero key in idle cycles
        if (valid_d) begin
            key_out <= key_next;
        end else begin
            key_out <= '0;
        end
        // mask table output lines up with the containers
        key_mask_out <= mask;
    end

endmodule

//--- source/key_execute.sv
`timescale 1ns/1ns
// execute stage of the key extractor
// two cycle phv delay, container split of the stage 1 phv,
// comparator operand fetch and compare for this stage's opcode slot
module key_execute #(
    parameter int STAGE_ID = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  key_extract_pkg::phv_t     phv_in,
    input  logic                      phv_valid,
    output key_extract_pkg::phv_t     phv_d,
    output logic                      valid_d,
    output key_extract_pkg::cont_6b_t cont_6b,
    output key_extract_pkg::cont_4b_t cont_4b,
    output key_extract_pkg::cont_2b_t cont_2b,
    output logic                      cmp_bit
);

    // slot 0 is the highest opcode, slot 4 starts at op_base
    localparam int op_lsb = key_extract_pkg::op_base
                          + (key_extract_pkg::num_slots - 1 - STAGE_ID) * key_extract_pkg::op_w;

    key_extract_pkg::phv_t phv_s1;
    logic                  valid_s1;
    key_extract_pkg::op_t  op_r;
    logic [7:0]            opnd_a;
    logic [7:0]            opnd_b;

    // 9-bit operand descriptor: immediate flag, then immediate byte
    // or size code in 4:3 and container index in 2:0
    function automatic logic [7:0] fetch_operand(
        input logic [8:0]                desc,
        input key_extract_pkg::cont_6b_t c6,
        input key_extract_pkg::cont_4b_t c4,
        input key_extract_pkg::cont_2b_t c2
    );
        logic [7:0] val;
        if (desc[8]) begin
            val = desc[7:0];
        end else begin
            case (desc[4:3])
                2'b10:   val = c6[desc[2:0]][7:0];
                2'b01:   val = c4[desc[2:0]][7:0];
                default: val = c2[desc[2:0]][7:0];
            endcase
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_d  <= 1'b0;
        end else begin
            valid_s1 <= phv_valid;
            valid_d  <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        phv_s1  <= phv_in;
        phv_d   <= phv_s1;
        cont_6b <= phv_s1[key_extract_pkg::cont_6b_lsb +:
                          key_extract_pkg::num_cont * key_extract_pkg::width_6b];
        cont_4b <= phv_s1[key_extract_pkg::cont_4b_lsb +:
                          key_extract_pkg::num_cont * key_extract_pkg::width_4b];
        cont_2b <= phv_s1[key_extract_pkg::cont_2b_lsb +:
                          key_extract_pkg::num_cont * key_extract_pkg::width_2b];
        op_r    <= phv_s1[op_lsb +: key_extract_pkg::op_w];
    end

    assign opnd_a = fetch_operand(op_r[17:9], cont_6b, cont_4b, cont_2b);
    assign opnd_b = fetch_operand(op_r[8:0], cont_6b, cont_4b, cont_2b);

    // compare kind in the top two opcode bits
    always_comb begin
        case (op_r[19:18])
            2'd0:    cmp_bit = opnd_a > opnd_b;
            2'd1:    cmp_bit = opnd_a >= opnd_b;
            2'd2:    cmp_bit = opnd_a == opnd_b;
            default: cmp_bit = 1'b1;
        endcase
    end

endmodule

//--- source/key_table.sv
`timescale 1ns/1ns
// tenant table with one write port and one read port
// two read registers give block ram style latency
module key_table #(
    parameter type entry_t = logic [7:0]
) (
    input  logic                                 clk,
    input  logic                                 wr_en,
    input  logic [key_extract_pkg::tenant_w-1:0] wr_index,
    input  entry_t                               wr_data,
    input  logic [key_extract_pkg::tenant_w-1:0] rd_index,
    output entry_t                               rd_data
);

    entry_t mem [key_extract_pkg::table_depth];
    // first read stage, ram output latch
    entry_t rd_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_q    <= mem[rd_index];
        rd_data <= rd_q;
    end

endmodule

//--- source/ctrl_decode.sv
`timescale 1ns/1ns
// control stream decoder
// packets addressed to this extractor become offset or mask table writes,
// all other packets are forwarded one cycle later
module ctrl_decode #(
    parameter int STAGE_ID  = 0,
    parameter int KEY_EX_ID = 0
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  key_extract_pkg::ctrl_t               ctrl_data,
    input  logic                                 ctrl_valid,
    input  logic                                 ctrl_last,
    output logic [key_extract_pkg::tenant_w-1:0] wr_index,
    output logic                                 off_wr_en,
    output logic                                 mask_wr_en,
    output key_extract_pkg::ctrl_t               wr_data,
    output key_extract_pkg::ctrl_t               ctrl_data_out,
    output logic                                 ctrl_valid_out,
    output logic                                 ctrl_last_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_wr_off,
        st_wr_mask
    } state_t;

    localparam logic [key_extract_pkg::stage_w-1:0] stage_code =
        STAGE_ID[key_extract_pkg::stage_w-1:0];
    localparam logic [key_extract_pkg::ex_id_w-1:0] ex_code =
        KEY_EX_ID[key_extract_pkg::ex_id_w-1:0];

    state_t                                  state;
    // set between header and last beat of a packet being forwarded
    logic                                    in_fwd_pkt;
    logic [key_extract_pkg::mod_id_w-1:0]    mod_id;
    logic [key_extract_pkg::tbl_sel_w-1:0]   tbl_sel;
    logic [key_extract_pkg::tenant_w-1:0]    start_idx;
    logic                                    hdr_match;
    logic                                    fwd_beat;

    assign mod_id    = ctrl_data[key_extract_pkg::mod_id_lsb +: key_extract_pkg::mod_id_w];
    assign tbl_sel   = ctrl_data[key_extract_pkg::tbl_sel_lsb +: key_extract_pkg::tbl_sel_w];
    assign start_idx = ctrl_data[key_extract_pkg::start_idx_lsb +: key_extract_pkg::tenant_w];

    // only the first beat of a packet is looked at as a header
    assign hdr_match = ctrl_valid && state == st_idle && !in_fwd_pkt
                    && mod_id[key_extract_pkg::ex_id_w +: key_extract_pkg::stage_w] == stage_code
                    && mod_id[key_extract_pkg::ex_id_w-1:0] == ex_code;
    assign fwd_beat  = ctrl_valid && state == st_idle && !hdr_match;

    // data beats go straight into the selected table
    assign off_wr_en  = ctrl_valid && state == st_wr_off;
    assign mask_wr_en = ctrl_valid && state == st_wr_mask;
    assign wr_data    = ctrl_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= st_idle;
            in_fwd_pkt     <= 1'b0;
            wr_index       <= '0;
            ctrl_valid_out <= 1'b0;
            ctrl_last_out  <= 1'b0;
        end else begin
            ctrl_valid_out <= fwd_beat;
            ctrl_last_out  <= fwd_beat && ctrl_last;
            case (state)
                st_idle: begin
                    if (hdr_match) begin
                        wr_index <= start_idx;
                        // a header with nothing behind it writes nothing
                        if (!ctrl_last) begin
                            if (tbl_sel == '0) begin
                                state <= st_wr_off;
                            end else begin
                                state <= st_wr_mask;
                            end
                        end
                    end else if (fwd_beat) begin
                        in_fwd_pkt <= !ctrl_last;
                    end
                end
                st_wr_off, st_wr_mask: begin
                    // index wraps modulo the table depth
                    if (ctrl_valid) begin
                        wr_index <= wr_index + 1'b1;
                        if (ctrl_last) begin
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_beat) begin
            ctrl_data_out <= ctrl_data;
        end
    end

endmodule

//--- source/key_extract_pkg.sv
// shared definitions for the key extraction stage
// phv container layout, comparator opcode slots, key and table entry types
// control header field positions
package key_extract_pkg;

    // container widths in bits, eight containers of each size
    localparam int width_2b   = 16;
    localparam int width_4b   = 32;
    localparam int width_6b   = 48;
    localparam int num_cont   = 8;
    localparam int cont_idx_w = $clog2(num_cont);

    // five comparator opcode slots sit above the metadata
    localparam int num_slots = 5;
    localparam int op_w      = 20;
    localparam int meta_w    = 256;
    localparam int op_base   = meta_w;

    localparam int phv_len = num_cont * (width_6b + width_4b + width_2b)
                           + num_slots * op_w + meta_w;

    // lowest bit of each container group, 6B group at the top of the phv
    localparam int cont_2b_lsb = op_base + num_slots * op_w;
    localparam int cont_4b_lsb = cont_2b_lsb + num_cont * width_2b;
    localparam int cont_6b_lsb = cont_4b_lsb + num_cont * width_4b;

    // vlan id inside the metadata, bits 7:4 pick the tenant
    localparam int vlan_lsb = 129;
    localparam int vlan_msb = 140;

    // two 6B, two 4B, two 2B containers plus one bit per comparator slot
    localparam int key_len = 2 * (width_6b + width_4b + width_2b) + num_slots;

    localparam int tenant_w    = 4;
    localparam int table_depth = 1 << tenant_w;

    typedef logic [phv_len-1:0] phv_t;
    typedef logic [key_len-1:0] key_t;
    typedef logic [key_len-1:0] mask_t;
    typedef logic [op_w-1:0]    op_t;

    typedef logic [num_cont-1:0][width_2b-1:0] cont_2b_t;
    typedef logic [num_cont-1:0][width_4b-1:0] cont_4b_t;
    typedef logic [num_cont-1:0][width_6b-1:0] cont_6b_t;

    // one tenant's container selection, 18 bits, high 6B slot first
    typedef struct packed {
        logic [cont_idx_w-1:0] sel_6b_hi;
        logic [cont_idx_w-1:0] sel_6b_lo;
        logic [cont_idx_w-1:0] sel_4b_hi;
        logic [cont_idx_w-1:0] sel_4b_lo;
        logic [cont_idx_w-1:0] sel_2b_hi;
        logic [cont_idx_w-1:0] sel_2b_lo;
    } offset_t;

    // control beat and header fields
    localparam int ctrl_width    = 256;
    localparam int mod_id_lsb    = 248;
    localparam int mod_id_w      = 8;
    localparam int stage_w       = 5;
    localparam int ex_id_w       = 3;
    localparam int tbl_sel_lsb   = 244;
    localparam int tbl_sel_w     = 4;
    localparam int start_idx_lsb = 240;

    typedef logic [ctrl_width-1:0] ctrl_t;

endpackage
